/* iic_reg_table.sv */
/*
 * decoder configuration table and the write sequencer,
 * restarted by a falling edge of the field marker
 */
`timescale 1ns/10ps
`include "vidin_cfg.svh"

module iic_reg_table
(
   input  logic                  tm3_clk_v0,
   input  logic                  rst,
   input  logic                  tm3_vidin_rts0,
   input  logic                  iic_busy,
   output vidin_pkg::iic_write_s iic_write,
   output logic                  iic_start
);

   localparam int NUM_WRITES = `VIDIN_IIC_NUM_WRITES;
   localparam int IDX_W      = $clog2(NUM_WRITES);

   logic [IDX_W-1:0]      idx;
   logic                  active;
   logic [2:0]            rts_sync;
   logic                  rts_fall;
   logic                  restart_req;
   logic                  take_restart;
   logic                  issue;
   vidin_pkg::iic_write_s entry;

   always_comb
   begin
      case (idx)
         0:       entry = '{8'h02, 8'hC0};
         1:       entry = '{8'h03, 8'h23};
         2:       entry = '{8'h06, 8'hEB};
         3:       entry = '{8'h07, 8'hE0};
         4:       entry = '{8'h08, 8'h80};
         5:       entry = '{8'h09, 8'h01};
         6:       entry = '{8'h0A, 8'h80};
         7:       entry = '{8'h0B, 8'h47};
         8:       entry = '{8'h0C, 8'h40};
         9:       entry = '{8'h0E, 8'h01};
         10:      entry = '{8'h10, 8'h00};
         11:      entry = '{8'h11, 8'h1C};
         12:      entry = '{8'h12, 8'h09};
         default: entry = '0;
      endcase
   end

   // bits 1..0 synchronize, bit 2 is the previous synchronized level
   assign rts_fall = rts_sync[2] && !rts_sync[1];

   // a start pulse in flight has not raised busy yet
   assign take_restart = restart_req && !iic_busy && !iic_start;
   assign issue        = active && !take_restart && !iic_busy && !iic_start;

   always_ff @(posedge tm3_clk_v0)
   begin
      if (!rst)
      begin
         rts_sync    <= '0;
         restart_req <= 1'b0;
         idx         <= '0;
         active      <= 1'b1;
         iic_start   <= 1'b0;
      end
      else
      begin
         rts_sync  <= {rts_sync[1:0], tm3_vidin_rts0};
         iic_start <= issue;

         if (take_restart)
         begin
            idx    <= '0;
            active <= 1'b1;
         end
         else if (issue)
         begin
            if (idx == IDX_W'(NUM_WRITES - 1))
            begin
               idx    <= '0;
               active <= 1'b0;
            end
            else
            begin
               idx <= idx + 1'b1;
            end
         end

         if (rts_fall)
         begin
            restart_req <= 1'b1;
         end
         else if (take_restart)
         begin
            restart_req <= 1'b0;
         end
      end
   end

   always_ff @(posedge tm3_clk_v0)
   begin
      if (issue)
      begin
         iic_write <= entry;
      end
   end

endmodule

/* iic_write_master.sv */
/*
 * write-only bus master: phase divider, start/slot/stop sequencing
 * and the three-byte shift source behind SDA
 */
`timescale 1ns/10ps
`include "vidin_cfg.svh"

module iic_write_master
(
   input  logic                  tm3_clk_v0,
   input  logic                  rst,
   input  vidin_pkg::iic_write_s iic_write,
   input  logic                  iic_start,
   output logic                  iic_busy,
   output logic                  tm3_vidin_scl,
   output logic                  tm3_vidin_sda
);

   localparam int PHASE_CYCLES = `VIDIN_IIC_PHASE_CYCLES;
   localparam int DIV_W        = $clog2(PHASE_CYCLES + 1);

   typedef enum logic [1:0] {ST_IDLE, ST_START, ST_SLOT, ST_STOP} state_t;

   state_t           state;
   logic [DIV_W-1:0] div_cnt;
   logic [1:0]       step;
   logic [1:0]       byte_cnt;
   logic [3:0]       bit_cnt;
   logic [23:0]      shift;
   logic             phase_end;
   logic             ack_slot;
   logic             scl_next;
   logic             sda_next;

   assign iic_busy  = (state != ST_IDLE);
   assign phase_end = (div_cnt == DIV_W'(PHASE_CYCLES - 1));
   // ninth slot of each byte, driven low by the master
   assign ack_slot  = (bit_cnt == 4'd8);

   always_ff @(posedge tm3_clk_v0)
   begin
      if (!rst)
      begin
         state    <= ST_IDLE;
         div_cnt  <= '0;
         step     <= '0;
         byte_cnt <= '0;
         bit_cnt  <= '0;
      end
      else if (state == ST_IDLE)
      begin
         if (iic_start)
         begin
            state    <= ST_START;
            div_cnt  <= '0;
            step     <= '0;
            byte_cnt <= '0;
            bit_cnt  <= '0;
         end
      end
      else if (!phase_end)
      begin
         div_cnt <= div_cnt + 1'b1;
      end
      else
      begin
         div_cnt <= '0;
         case (state)
            ST_START:
            begin
               step  <= (step == 2'd1) ? 2'd0 : step + 1'b1;
               state <= (step == 2'd1) ? ST_SLOT : ST_START;
            end
            ST_SLOT:
            begin
               if (step != 2'd2)
               begin
                  step <= step + 1'b1;
               end
               else
               begin
                  step <= '0;
                  if (!ack_slot)
                  begin
                     bit_cnt <= bit_cnt + 1'b1;
                  end
                  else
                  begin
                     bit_cnt  <= '0;
                     byte_cnt <= byte_cnt + 1'b1;
                     if (byte_cnt == 2'd2)
                     begin
                        state <= ST_STOP;
                     end
                  end
               end
            end
            ST_STOP:
            begin
               step  <= step + 1'b1;
               state <= (step == 2'd1) ? ST_IDLE : ST_STOP;
            end
            default: state <= ST_IDLE;
         endcase
      end
   end

   // device address, sub-address, data, msb first
   always_ff @(posedge tm3_clk_v0)
   begin
      if ((state == ST_IDLE) && iic_start)
      begin
         shift <= {`VIDIN_IIC_DEV_ADDR, iic_write.sub_addr, iic_write.data};
      end
      else if ((state == ST_SLOT) && phase_end && (step == 2'd2) && !ack_slot)
      begin
         shift <= {shift[22:0], 1'b0};
      end
   end

   always_comb
   begin
      scl_next = 1'b1;
      sda_next = 1'b1;
      case (state)
         ST_START: sda_next = (step == 2'd0);
         ST_SLOT:
         begin
            scl_next = (step == 2'd1);
            sda_next = ack_slot ? 1'b0 : shift[23];
         end
         ST_STOP:  sda_next = (step == 2'd1);
         default:  sda_next = 1'b1;
      endcase
   end

   always_ff @(posedge tm3_clk_v0)
   begin
      if (!rst)
      begin
         tm3_vidin_scl <= 1'b1;
         tm3_vidin_sda <= 1'b1;
      end
      else
      begin
         tm3_vidin_scl <= scl_next;
         tm3_vidin_sda <= sda_next;
      end
   end

endmodule

/* tb_vidin_front_end.sv */
/*
 * testbench for the video front end with clock and reset, video and
 * field-marker stimulus, bus decoder, reference model and comparison
 */
`timescale 1ns/10ps
`include "vidin_cfg.svh"

module tb_vidin_front_end;

   localparam int NUM_WRITES    = `VIDIN_IIC_NUM_WRITES;
   localparam int WRITE_TIMEOUT = 6000;
   localparam int IDLE_CYCLES   = 500;
   localparam int DRAIN_TIMEOUT = 50;
   localparam int FRAME_LINES   = 4;
   localparam int LINE_PIXELS   = 8;

   logic                     tm3_clk_v0;
   logic                     rst;
   logic [`VIDIN_VPO_W-1:0]  tm3_vidin_vpo;
   logic                     tm3_vidin_cref;
   logic                     tm3_vidin_href;
   logic                     tm3_vidin_vs;
   logic                     tm3_vidin_rts0;
   logic                     tm3_vidin_sda;
   logic                     tm3_vidin_scl;
   logic                     vidin_new_data;
   logic [23:0]              vidin_rgb_reg;
   logic [`VIDIN_ADDR_W-1:0] vidin_addr_reg;

   integer seed;
   int     cycle_cnt = 0;
   int     mismatch_count;
   int     failure_count;

   // expected pixels, addresses and sampling edges in output order
   logic [23:0]              exp_pixel_q[$];
   logic [`VIDIN_ADDR_W-1:0] exp_addr_q[$];
   int                       exp_cycle_q[$];

   // counting model
   logic [`VIDIN_HORIZ_W-1:0] model_horiz;
   logic [`VIDIN_VERT_W-1:0]  model_vert;
   logic [15:0]               model_hi_word;
   logic                      model_prev_cref;

   // bus decoder state
   logic        prev_scl;
   logic        prev_sda;
   logic        in_write;
   logic [27:0] bus_bits;
   int          bit_count;
   int          write_count;

   vidin_front_end u_vidin_front_end
   (
      .tm3_clk_v0     (tm3_clk_v0),
      .rst            (rst),
      .tm3_vidin_vpo  (tm3_vidin_vpo),
      .tm3_vidin_cref (tm3_vidin_cref),
      .tm3_vidin_href (tm3_vidin_href),
      .tm3_vidin_vs   (tm3_vidin_vs),
      .tm3_vidin_rts0 (tm3_vidin_rts0),
      .tm3_vidin_sda  (tm3_vidin_sda),
      .tm3_vidin_scl  (tm3_vidin_scl),
      .vidin_new_data (vidin_new_data),
      .vidin_rgb_reg  (vidin_rgb_reg),
      .vidin_addr_reg (vidin_addr_reg)
   );

   initial
   begin
      tm3_clk_v0 = 1'b0;
      forever
      begin
         #20 tm3_clk_v0 = ~tm3_clk_v0;
      end
   end

   always @(posedge tm3_clk_v0)
   begin
      cycle_cnt <= cycle_cnt + 1;
   end

   // red 7..3 and 2..0, green 7..5, 4..2 and 1..0, blue 7..3 and 2..0
   function automatic logic [23:0] pixel_ref(input logic [15:0] hi, input logic [15:0] lo);
      logic [7:0] red;
      logic [7:0] green;
      logic [7:0] blue;
      red   = {hi[15:11], hi[7:5]};
      green = {hi[10:8], lo[7:5], hi[4:3]};
      blue  = {lo[4:0], hi[2:0]};
      return {red, green, blue};
   endfunction

   function automatic logic [`VIDIN_ADDR_W-1:0] addr_ref(
      input logic [`VIDIN_VERT_W-1:0]  vert,
      input logic [`VIDIN_HORIZ_W-1:0] horiz);
      return {2'b00, vert, horiz[`VIDIN_HORIZ_W-1:1]};
   endfunction

   // decoder configuration with the sub-address in the upper byte
   function automatic logic [15:0] table_entry(input int idx);
      case (idx)
         0:       return 16'h02C0;
         1:       return 16'h0323;
         2:       return 16'h06EB;
         3:       return 16'h07E0;
         4:       return 16'h0880;
         5:       return 16'h0901;
         6:       return 16'h0A80;
         7:       return 16'h0B47;
         8:       return 16'h0C40;
         9:       return 16'h0E01;
         10:      return 16'h1000;
         11:      return 16'h111C;
         default: return 16'h1209;
      endcase
   endfunction

   task automatic check_value(input string name, input logic [31:0] actual,
                              input logic [31:0] expected);
      if (actual !== expected)
      begin
         mismatch_count++;
         $display("ERROR %s: got %h, expected %h", name, actual, expected);
      end
   endtask

   task automatic report_failure(input string msg);
      failure_count++;
      $display("%s", msg);
   endtask

   // device in bits 27..20 and sub-address in 18..11, data in 9..2
   // acks in 19, 10 and 1, and the stop clock in bit 0
   task automatic check_write;
      logic [15:0] entry;
      entry = table_entry(write_count % NUM_WRITES);
      if (!in_write)
      begin
         report_failure("stop condition on the bus without a start");
      end
      else if (bit_count != 28)
      begin
         report_failure($sformatf("bus write had %0d clock pulses instead of 28", bit_count));
      end
      else
      begin
         check_value("iic device byte", bus_bits[27:20], `VIDIN_IIC_DEV_ADDR);
         check_value("iic ack bits", {bus_bits[19], bus_bits[10], bus_bits[1]}, 3'b000);
         check_value("iic sub_addr", bus_bits[18:11], entry[15:8]);
         check_value("iic data", bus_bits[9:2], entry[7:0]);
      end
      write_count = write_count + 1;
   endtask

   always @(negedge tm3_clk_v0)
   begin
      if (rst)
      begin
         if (prev_scl && tm3_vidin_scl && prev_sda && !tm3_vidin_sda)
         begin
            in_write  = 1'b1;
            bit_count = 0;
         end
         else if (prev_scl && tm3_vidin_scl && !prev_sda && tm3_vidin_sda)
         begin
            check_write();
            in_write = 1'b0;
         end
         else if (!prev_scl && tm3_vidin_scl)
         begin
            bus_bits  = {bus_bits[26:0], tm3_vidin_sda};
            bit_count = bit_count + 1;
         end
      end
      prev_scl = tm3_vidin_scl;
      prev_sda = tm3_vidin_sda;
   end

   always @(negedge tm3_clk_v0)
   begin
      if (rst && (vidin_new_data === 1'b1))
      begin
         if (exp_cycle_q.size() == 0)
         begin
            report_failure("vidin_new_data pulse with no pixel expected");
         end
         else
         begin
            check_value("vidin_rgb_reg", vidin_rgb_reg, exp_pixel_q.pop_front());
            check_value("vidin_addr_reg", vidin_addr_reg, exp_addr_q.pop_front());
            check_value("vidin_new_data delay", cycle_cnt - exp_cycle_q.pop_front(), 2);
         end
      end
   end

   // one input cycle with the counting model stepped alongside
   task automatic drive_cycle(input logic vs, input logic href, input logic cref,
                              input logic [15:0] word);
      logic [`VIDIN_VERT_W-1:0] next_vert;
      @(negedge tm3_clk_v0);
      tm3_vidin_vs   = vs;
      tm3_vidin_href = href;
      tm3_vidin_cref = cref;
      tm3_vidin_vpo  = word;
      if (cref)
      begin
         model_hi_word = word;
      end
      else if (model_prev_cref && !tm3_vidin_rts0 && !model_horiz[0])
      begin
         exp_pixel_q.push_back(pixel_ref(model_hi_word, word));
         exp_addr_q.push_back(addr_ref(model_vert, model_horiz));
         exp_cycle_q.push_back(cycle_cnt + 1);
      end
      next_vert = vs ? '0 : ((!href && (model_horiz != 0)) ? model_vert + 1'b1 : model_vert);
      if (!href)
      begin
         model_horiz = '0;
      end
      else if (!cref)
      begin
         model_horiz = model_horiz + 1'b1;
      end
      model_vert      = next_vert;
      model_prev_cref = cref;
   endtask

   task automatic set_field_marker(input logic value);
      @(negedge tm3_clk_v0);
      tm3_vidin_rts0 = value;
   endtask

   task automatic send_frame;
      logic [15:0] word;
      drive_cycle(1'b1, 1'b0, 1'b1, 16'h0000);
      drive_cycle(1'b1, 1'b0, 1'b1, 16'h0000);
      repeat (3) drive_cycle(1'b0, 1'b0, 1'b1, 16'h0000);
      for (int line = 0; line < FRAME_LINES; line++)
      begin
         for (int pix = 0; pix < LINE_PIXELS; pix++)
         begin
            word = $random(seed);
            drive_cycle(1'b0, 1'b1, 1'b1, word);
            word = $random(seed);
            drive_cycle(1'b0, 1'b1, 1'b0, word);
         end
         // cref held high through blanking
         repeat (4) drive_cycle(1'b0, 1'b0, 1'b1, 16'h0000);
      end
   endtask

   task automatic wait_writes(input int target);
      int waited;
      waited = 0;
      while ((write_count < target) && (waited < WRITE_TIMEOUT))
      begin
         @(negedge tm3_clk_v0);
         waited++;
      end
      if (write_count < target)
      begin
         report_failure($sformatf("timed out waiting for bus write %0d", target));
      end
   endtask

   task automatic wait_video_drain;
      int waited;
      waited = 0;
      while ((exp_cycle_q.size() != 0) && (waited < DRAIN_TIMEOUT))
      begin
         @(negedge tm3_clk_v0);
         waited++;
      end
      if (exp_cycle_q.size() != 0)
      begin
         report_failure("timed out waiting for expected vidin_new_data pulses");
      end
   endtask

   task automatic check_bus_idle(input int expected_writes);
      for (int i = 0; i < IDLE_CYCLES; i++)
      begin
         @(negedge tm3_clk_v0);
         check_value("tm3_vidin_scl", tm3_vidin_scl, 1'b1);
         check_value("tm3_vidin_sda", tm3_vidin_sda, 1'b1);
      end
      check_value("bus write count", write_count, expected_writes);
   endtask

   initial
   begin
      seed            = 75044;
      mismatch_count  = 0;
      failure_count   = 0;
      model_horiz     = '0;
      model_vert      = '0;
      model_hi_word   = '0;
      model_prev_cref = 1'b1;
      prev_scl        = 1'b1;
      prev_sda        = 1'b1;
      in_write        = 1'b0;
      bus_bits        = '0;
      bit_count       = 0;
      write_count     = 0;
      rst             = 1'b0;
      tm3_vidin_vpo   = '0;
      tm3_vidin_cref  = 1'b1;
      tm3_vidin_href  = 1'b0;
      tm3_vidin_vs    = 1'b0;
      tm3_vidin_rts0  = 1'b0;
      repeat (3) @(negedge tm3_clk_v0);
      rst = 1'b1;

      // table after reset followed by a quiet bus
      wait_writes(NUM_WRITES);
      check_bus_idle(NUM_WRITES);

      // falling field marker replays the table
      set_field_marker(1'b1);
      repeat (4) drive_cycle(1'b0, 1'b0, 1'b1, 16'h0000);
      set_field_marker(1'b0);
      wait_writes(2 * NUM_WRITES);
      check_bus_idle(2 * NUM_WRITES);

      // even field frame
      send_frame();
      wait_video_drain();

      // odd field frame where any pulse is unexpected
      set_field_marker(1'b1);
      send_frame();
      repeat (4) drive_cycle(1'b0, 1'b0, 1'b1, 16'h0000);
      check_value("bus write count", write_count, 2 * NUM_WRITES);

      $display("checks done: %0d value mismatches, %0d other failures",
               mismatch_count, failure_count);
      if ((mismatch_count == 0) && (failure_count == 0))
      begin
         $display("ALL CHECKS PASSED");
      end
      else
      begin
         $display("CHECKS FAILED");
      end
      $finish;
   end

endmodule

/* vidin_cfg.svh */
/*
 * widths of the video word, position counters and frame address,
 * plus the decoder bus constants: device address, phase length
 * and the length of the configuration table
 */
`ifndef VIDIN_CFG_SVH
`define VIDIN_CFG_SVH

// video stream from the decoder
`define VIDIN_VPO_W 16

// column and line counters
`define VIDIN_HORIZ_W 10
`define VIDIN_VERT_W 8

// frame address presented with each kept pixel
`define VIDIN_ADDR_W 19

// write address of the decoder, first byte of every write
`define VIDIN_IIC_DEV_ADDR 8'h48

// clock cycles per bus phase
`define VIDIN_IIC_PHASE_CYCLES 4

// number of (sub-address, data) pairs sent after reset
`define VIDIN_IIC_NUM_WRITES 13

`endif

/* vidin_front_end.sv */
/*
 * video input front end: pixel capture and decimation,
 * decoder configuration table and bus master
 */
`timescale 1ns/10ps
`include "vidin_cfg.svh"

module vidin_front_end
(
   input  logic                     tm3_clk_v0,
   input  logic                     rst,
   input  logic [`VIDIN_VPO_W-1:0]  tm3_vidin_vpo,
   input  logic                     tm3_vidin_cref,
   input  logic                     tm3_vidin_href,
   input  logic                     tm3_vidin_vs,
   input  logic                     tm3_vidin_rts0,
   output logic                     tm3_vidin_sda,
   output logic                     tm3_vidin_scl,
   output logic                     vidin_new_data,
   output vidin_pkg::rgb_pixel_s    vidin_rgb_reg,
   output logic [`VIDIN_ADDR_W-1:0] vidin_addr_reg
);

   vidin_pkg::rgb_pixel_s pixel;
   vidin_pkg::pixel_pos_s pos;
   logic                  pixel_valid;
   vidin_pkg::iic_write_s iic_write;
   logic                  iic_start;
   logic                  iic_busy;

   vidin_pixel_capture u_pixel_capture
   (
      .tm3_clk_v0     (tm3_clk_v0),
      .rst            (rst),
      .tm3_vidin_vpo  (tm3_vidin_vpo),
      .tm3_vidin_cref (tm3_vidin_cref),
      .tm3_vidin_href (tm3_vidin_href),
      .tm3_vidin_vs   (tm3_vidin_vs),
      .tm3_vidin_rts0 (tm3_vidin_rts0),
      .pixel          (pixel),
      .pos            (pos),
      .pixel_valid    (pixel_valid)
   );

   vidin_pixel_select u_pixel_select
   (
      .tm3_clk_v0     (tm3_clk_v0),
      .rst            (rst),
      .pixel          (pixel),
      .pos            (pos),
      .pixel_valid    (pixel_valid),
      .vidin_new_data (vidin_new_data),
      .vidin_rgb_reg  (vidin_rgb_reg),
      .vidin_addr_reg (vidin_addr_reg)
   );

   iic_reg_table u_reg_table
   (
      .tm3_clk_v0     (tm3_clk_v0),
      .rst            (rst),
      .tm3_vidin_rts0 (tm3_vidin_rts0),
      .iic_busy       (iic_busy),
      .iic_write      (iic_write),
      .iic_start      (iic_start)
   );

   iic_write_master u_write_master
   (
      .tm3_clk_v0    (tm3_clk_v0),
      .rst           (rst),
      .iic_write     (iic_write),
      .iic_start     (iic_start),
      .iic_busy      (iic_busy),
      .tm3_vidin_scl (tm3_vidin_scl),
      .tm3_vidin_sda (tm3_vidin_sda)
   );

endmodule

/* vidin_front_end_checker.sv */
/*
 * concurrent assertions on the front-end outputs,
 * bound to the top level
 */
`timescale 1ns/10ps
`include "vidin_cfg.svh"

module vidin_front_end_checker
(
   input logic                     tm3_clk_v0,
   input logic                     rst,
   input logic                     vidin_new_data,
   input logic [`VIDIN_ADDR_W-1:0] vidin_addr_reg,
   input logic                     tm3_vidin_scl,
   input logic                     tm3_vidin_sda
);

   // strobe is a single-cycle pulse
   property new_data_single;
      @(posedge tm3_clk_v0) disable iff (!rst)
         vidin_new_data |=> !vidin_new_data;
   endproperty

   // two zero bits above the line number
   property addr_pad_zero;
      @(posedge tm3_clk_v0) disable iff (!rst)
         vidin_new_data |-> (vidin_addr_reg[`VIDIN_ADDR_W-1:`VIDIN_ADDR_W-2] == 2'b00);
   endproperty

   property reset_outputs;
      @(posedge tm3_clk_v0)
         !rst |=> (!vidin_new_data && tm3_vidin_scl && tm3_vidin_sda);
   endproperty

   new_data_single_a: assert property (new_data_single)
      else $error("vidin_new_data high on two cycles in a row");

   addr_pad_zero_a: assert property (addr_pad_zero)
      else $error("vidin_addr_reg upper bits not zero with vidin_new_data");

   reset_outputs_a: assert property (reset_outputs)
      else $error("outputs not at idle values after reset");

endmodule

bind vidin_front_end vidin_front_end_checker u_checker
(
   .tm3_clk_v0     (tm3_clk_v0),
   .rst            (rst),
   .vidin_new_data (vidin_new_data),
   .vidin_addr_reg (vidin_addr_reg),
   .tm3_vidin_scl  (tm3_vidin_scl),
   .tm3_vidin_sda  (tm3_vidin_sda)
);

/* vidin_pixel_capture.sv */
/*
 * column and line counters, two-phase pixel assembly
 * and the position latch for each pixel
 */
`timescale 1ns/10ps
`include "vidin_cfg.svh"

module vidin_pixel_capture
(
   input  logic                  tm3_clk_v0,
   input  logic                  rst,
   input  vidin_pkg::vpo_word_u  tm3_vidin_vpo,
   input  logic                  tm3_vidin_cref,
   input  logic                  tm3_vidin_href,
   input  logic                  tm3_vidin_vs,
   input  logic                  tm3_vidin_rts0,
   output vidin_pkg::rgb_pixel_s pixel,
   output vidin_pkg::pixel_pos_s pos,
   output logic                  pixel_valid
);

   logic [`VIDIN_HORIZ_W-1:0] horiz;
   logic [`VIDIN_VERT_W-1:0]  vert;
   vidin_pkg::vpo_hi_s        hi_word;
   logic                      hi_seen;
   logic                      lo_taken;
   logic                      merge;

   // second half of a pixel: cref low right after a cref-high word
   assign merge = !tm3_vidin_cref && hi_seen;

   always_ff @(posedge tm3_clk_v0)
   begin
      if (!rst)
      begin
         horiz <= '0;
         vert  <= '0;
      end
      else
      begin
         if (!tm3_vidin_href)
         begin
            horiz <= '0;
         end
         else if (!tm3_vidin_cref)
         begin
            horiz <= horiz + 1'b1;
         end

         // line end is the first href-low cycle after active video
         if (tm3_vidin_vs)
         begin
            vert <= '0;
         end
         else if (!tm3_vidin_href && (horiz != '0))
         begin
            vert <= vert + 1'b1;
         end
      end
   end

   always_ff @(posedge tm3_clk_v0)
   begin
      if (!rst)
      begin
         hi_seen     <= 1'b0;
         lo_taken    <= 1'b0;
         pixel_valid <= 1'b0;
      end
      else
      begin
         hi_seen     <= tm3_vidin_cref;
         lo_taken    <= merge;
         pixel_valid <= lo_taken;
      end
   end

   always_ff @(posedge tm3_clk_v0)
   begin
      if (tm3_vidin_cref)
      begin
         hi_word <= tm3_vidin_vpo.hi;
      end
   end

   // merge both halves, position taken before the column increment
   always_ff @(posedge tm3_clk_v0)
   begin
      if (merge)
      begin
         pixel.red   <= {hi_word.red_hi, hi_word.red_lo};
         pixel.green <= {hi_word.green_hi, tm3_vidin_vpo.lo.green_mid, hi_word.green_lo};
         pixel.blue  <= {tm3_vidin_vpo.lo.blue_hi, hi_word.blue_lo};
         pos.vert    <= vert;
         pos.field   <= tm3_vidin_rts0;
         pos.horiz   <= horiz;
      end
   end

endmodule

/* vidin_pixel_select.sv */
/*
 * field and column decimation, output pixel and frame address
 * registers with the new-data strobe
 */
`timescale 1ns/10ps
`include "vidin_cfg.svh"

module vidin_pixel_select
(
   input  logic                     tm3_clk_v0,
   input  logic                     rst,
   input  vidin_pkg::rgb_pixel_s    pixel,
   input  vidin_pkg::pixel_pos_s    pos,
   input  logic                     pixel_valid,
   output logic                     vidin_new_data,
   output vidin_pkg::rgb_pixel_s    vidin_rgb_reg,
   output logic [`VIDIN_ADDR_W-1:0] vidin_addr_reg
);

   // zero bits above the line number in the frame address
   localparam int PAD_W = `VIDIN_ADDR_W - `VIDIN_VERT_W - `VIDIN_HORIZ_W + 1;

   logic keep;

   // even field, even column only
   assign keep = pixel_valid && !pos.field && !pos.horiz[0];

   always_ff @(posedge tm3_clk_v0)
   begin
      if (!rst)
      begin
         vidin_new_data <= 1'b0;
      end
      else
      begin
         vidin_new_data <= keep;
      end
   end

   always_ff @(posedge tm3_clk_v0)
   begin
      if (keep)
      begin
         vidin_rgb_reg  <= pixel;
         vidin_addr_reg <= {{PAD_W{1'b0}}, pos.vert, pos.horiz[`VIDIN_HORIZ_W-1:1]};
      end
   end

endmodule

/* vidin_pkg.sv */
/*
 * video word views, pixel and position records,
 * and the register write carried to the bus master
 */
`include "vidin_cfg.svh"

package vidin_pkg;

   // word sampled while cref is high
   typedef struct packed {
      logic [4:0] red_hi;
      logic [2:0] green_hi;
      logic [2:0] red_lo;
      logic [1:0] green_lo;
      logic [2:0] blue_lo;
   } vpo_hi_s;

   // word sampled while cref is low, upper byte carries nothing
   typedef struct packed {
      logic [7:0] unused;
      logic [2:0] green_mid;
      logic [4:0] blue_hi;
   } vpo_lo_s;

   typedef union packed {
      vpo_hi_s hi;
      vpo_lo_s lo;
   } vpo_word_u;

   typedef struct packed {
      logic [7:0] red;
      logic [7:0] green;
      logic [7:0] blue;
   } rgb_pixel_s;

   typedef struct packed {
      logic [`VIDIN_VERT_W-1:0]  vert;
      logic                      field;
      logic [`VIDIN_HORIZ_W-1:0] horiz;
   } pixel_pos_s;

   typedef struct packed {
      logic [7:0] sub_addr;
      logic [7:0] data;
   } iic_write_s;

endpackage

/* vlog.f */
+incdir+.
vidin_pkg.sv
vidin_pixel_capture.sv
vidin_pixel_select.sv
iic_reg_table.sv
iic_write_master.sv
vidin_front_end.sv
vidin_front_end_checker.sv
tb_vidin_front_end.sv
